//--- dcu_consts.svh
`ifndef DCU_CONSTS_SVH
`define DCU_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Register numbers on the CPU side
//////////////////////////////////////////////////////////////////////

// Data port, pops one ROM byte per read
`define DCU_PORT_DATA        4'h0
// Directory base, low byte first
`define DCU_PORT_BASE0       4'h1
`define DCU_PORT_BASE1       4'h2
`define DCU_PORT_BASE2       4'h3
`define DCU_PORT_INDEX       4'h4
// Writing OFFSET1 starts a directory lookup
`define DCU_PORT_OFFSET0     4'h5
`define DCU_PORT_OFFSET1     4'h6
`define DCU_PORT_COUNTER0    4'h9
`define DCU_PORT_COUNTER1    4'hA
`define DCU_PORT_STATUS      4'hC

// Bit of STATUS that says bytes are waiting
`define DCU_STATUS_READY_BIT 7

//////////////////////////////////////////////////////////////////////
// ROM and buffer sizing
//////////////////////////////////////////////////////////////////////

// PSRAM needs this many quiet cycles per access
`define DCU_ROM_LATENCY      7
// Wide enough to hold DCU_ROM_LATENCY
`define DCU_ROM_CTR_W        4
// 16-bit word address
`define DCU_ROM_AW           23
// Byte pointer into ROM
`define DCU_PTR_W            24
`define DCU_RING_DEPTH       1024
// Ring occupancy, 0 up to DCU_RING_DEPTH inclusive
`define DCU_RING_CW          11

`endif

//--- dcu_pkg.sv
`default_nettype none
`include "dcu_consts.svh"

package dcu_pkg;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb_rsp_t;

    // Held by a client until done comes back
    typedef struct packed {
        logic                   valid;
        logic [`DCU_ROM_AW-1:0] addr;
    } rom_req_t;

    // Shared by both clients, done is a single cycle
    typedef struct packed {
        logic        done;
        logic [15:0] data;
    } rom_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } ring_wr_t;

    // Start pulse with the byte address of pointer byte 1 of the entry
    typedef struct packed {
        logic                  start;
        logic [`DCU_PTR_W-1:0] addr;
    } fetch_cmd_t;

endpackage

`default_nettype wire

//--- byte_ring.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcu_consts.svh"

module byte_ring #(
    parameter int DEPTH = `DCU_RING_DEPTH
) (
    input  wire                          CLK,
    input  wire                          arst_n,
    input  wire                          flush,
    input  wire dcu_pkg::ring_wr_t       wr,
    input  wire                          pop,
    output logic [$clog2(DEPTH+1)-1:0]   count,
    output logic [7:0]                   head
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;
    logic          do_wr;
    logic          do_pop;

    // Separate count keeps the last slot usable
    assign do_wr  = wr.valid && count != CW'(DEPTH);
    assign do_pop = pop && count != '0;
    assign head   = mem[rd_idx];

    always_ff @(posedge CLK) begin
        if (do_wr) begin
            mem[wr_idx] <= wr.data;
        end
    end

    // Indices wrap on their own with a power of two depth
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            wr_idx <= wr_idx + AW'(do_wr);
            rd_idx <= rd_idx + AW'(do_pop);
            count  <= count + CW'(do_wr) - CW'(do_pop);
        end
    end

endmodule

`default_nettype wire

//--- rom_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcu_consts.svh"

module rom_port (
    input  wire                     CLK,
    input  wire                     arst_n,
    input  wire                     flush,
    input  wire dcu_pkg::rom_req_t  loader_req,
    input  wire dcu_pkg::rom_req_t  prefetch_req,
    output dcu_pkg::rom_rsp_t       rsp,
    input  wire                     sfc_rom_rd,
    output logic                    rom_rd,
    output logic [`DCU_ROM_AW-1:0]  rom_addr,
    input  wire [15:0]              rom_data
);

    logic                      busy;
    logic [`DCU_ROM_CTR_W-1:0] ctr;

    // Cartridge reads own the PSRAM, we only drive in free cycles
    assign rom_rd = busy && !sfc_rom_rd;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            ctr      <= '0;
            rom_addr <= '0;
            rsp      <= '0;
        end else begin
            rsp.done <= 1'b0;
            if (flush) begin
                // Drop whatever was in flight
                busy <= 1'b0;
            end else if (busy) begin
                if (sfc_rom_rd) begin
                    // Pre-empted, timing starts over
                    ctr <= `DCU_ROM_CTR_W'(`DCU_ROM_LATENCY);
                end else if (ctr == `DCU_ROM_CTR_W'(1)) begin
                    busy     <= 1'b0;
                    rsp.done <= 1'b1;
                    rsp.data <= rom_data;
                end else begin
                    ctr <= ctr - 1'b1;
                end
            end else if (!rsp.done && (loader_req.valid || prefetch_req.valid)) begin
                // Client still holds valid during done, so skip that cycle
                // Loader wins over the prefetcher
                busy     <= 1'b1;
                ctr      <= `DCU_ROM_CTR_W'(`DCU_ROM_LATENCY);
                rom_addr <= loader_req.valid ? loader_req.addr : prefetch_req.addr;
            end
        end
    end

endmodule

`default_nettype wire

//--- dir_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcu_consts.svh"

module dir_loader (
    input  wire                       CLK,
    input  wire                       arst_n,
    input  wire dcu_pkg::fetch_cmd_t  fetch,
    output dcu_pkg::rom_req_t         req,
    input  wire dcu_pkg::rom_rsp_t    rsp,
    output logic                      ptr_valid,
    output logic [`DCU_PTR_W-1:0]     ptr
);

    // Byte address of the pointer byte being read
    logic [`DCU_PTR_W-1:0] byte_addr;
    // Bytes still to come after the current one
    logic [1:0]            left;
    logic                  busy;
    logic [7:0]            rd_byte;

    // Odd bytes live in the upper half of the word
    assign rd_byte = byte_addr[0] ? rsp.data[15:8] : rsp.data[7:0];

    always_comb begin
        req.valid = busy;
        req.addr  = byte_addr[`DCU_PTR_W-1:1];
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            left      <= '0;
            byte_addr <= '0;
            ptr       <= '0;
            ptr_valid <= 1'b0;
        end else begin
            ptr_valid <= 1'b0;
            if (fetch.start) begin
                // A new start overrides any walk in progress
                busy      <= 1'b1;
                left      <= 2'd2;
                byte_addr <= fetch.addr;
            end else if (busy && rsp.done) begin
                // Pointer is stored high byte first, shift in from the right
                ptr       <= {ptr[`DCU_PTR_W-9:0], rd_byte};
                byte_addr <= byte_addr + 1'b1;
                left      <= left - 1'b1;
                if (left == 2'd0) begin
                    busy      <= 1'b0;
                    ptr_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rom_prefetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcu_consts.svh"

module rom_prefetch (
    input  wire                     CLK,
    input  wire                     arst_n,
    input  wire                     flush,
    input  wire                     ptr_valid,
    input  wire [`DCU_PTR_W-1:0]    ptr,
    input  wire [`DCU_RING_CW-1:0]  ring_count,
    output dcu_pkg::rom_req_t       req,
    input  wire dcu_pkg::rom_rsp_t  rsp,
    output dcu_pkg::ring_wr_t       ring_wr
);

    // Stopped until the loader hands over a pointer
    typedef enum logic [1:0] {
        S_STOP,
        S_IDLE,
        S_WAIT,
        S_SECOND
    } state_t;

    state_t                state;
    // Byte pointer of the next byte to store
    logic [`DCU_PTR_W-1:0] cur;
    // Upper byte kept for the second write
    logic [7:0]            hi_q;
    logic                  room;

    // A whole word may land, so leave two free bytes
    assign room = ring_count <= `DCU_RING_DEPTH - 2;

    always_comb begin
        req.valid     = state == S_WAIT;
        req.addr      = cur[`DCU_PTR_W-1:1];
        ring_wr.valid = (state == S_WAIT && rsp.done) || state == S_SECOND;
        if (state == S_SECOND) begin
            ring_wr.data = hi_q;
        end else begin
            ring_wr.data = cur[0] ? rsp.data[15:8] : rsp.data[7:0];
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_STOP;
            cur   <= '0;
            hi_q  <= '0;
        end else if (flush) begin
            state <= S_STOP;
        end else if (ptr_valid) begin
            cur   <= ptr;
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    // Full ring just stalls here
                    if (room) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (rsp.done) begin
                        // First byte goes out with done
                        cur  <= cur + 1'b1;
                        hi_q <= rsp.data[15:8];
                        // Odd pointer used the high byte already
                        state <= cur[0] ? S_IDLE : S_SECOND;
                    end
                end
                S_SECOND: begin
                    cur   <= cur + 1'b1;
                    state <= S_IDLE;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dcu_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcu_consts.svh"

module dcu_regs (
    input  wire                     CLK,
    input  wire                     arst_n,
    input  wire dcu_pkg::wb_req_t   wb_req,
    output dcu_pkg::wb_rsp_t        wb_rsp,
    input  wire [`DCU_RING_CW-1:0]  ring_count,
    input  wire [7:0]               ring_head,
    output logic                    ring_pop,
    output dcu_pkg::fetch_cmd_t     fetch
);

    // Programmable state
    logic [`DCU_PTR_W-1:0] base;
    logic [7:0]            index;
    logic [15:0]           offset;
    logic [15:0]           length;

    // Set after ack until the master drops stb
    logic       hold;
    // Access taken this cycle, ack follows on the next
    logic       acc;
    logic       wr_acc;
    // OFFSET1 written, start goes out one cycle after ack
    logic       start_pend;
    logic       ring_ready;
    logic [7:0] rd_dat;

    assign ring_ready = ring_count != '0;
    assign acc        = wb_req.cyc && wb_req.stb && !wb_rsp.ack && !hold;
    assign wr_acc     = acc && wb_req.we;

    // One byte leaves the ring per accepted data read
    // Empty ring means no pop at all
    assign ring_pop = acc && !wb_req.we && wb_req.adr == `DCU_PORT_DATA && ring_ready;

    //////////////////////////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_dat = 8'h00;
        case (wb_req.adr)
            `DCU_PORT_DATA: begin
                if (ring_ready) begin
                    rd_dat = ring_head;
                end
            end
            `DCU_PORT_BASE0:    rd_dat = base[7:0];
            `DCU_PORT_BASE1:    rd_dat = base[15:8];
            `DCU_PORT_BASE2:    rd_dat = base[23:16];
            `DCU_PORT_INDEX:    rd_dat = index;
            `DCU_PORT_OFFSET0:  rd_dat = offset[7:0];
            `DCU_PORT_OFFSET1:  rd_dat = offset[15:8];
            `DCU_PORT_COUNTER0: rd_dat = length[7:0];
            `DCU_PORT_COUNTER1: rd_dat = length[15:8];
            `DCU_PORT_STATUS:   rd_dat[`DCU_STATUS_READY_BIT] = ring_ready;
            // Holes in the map read as zero
            default: ;
        endcase
    end

    // Bus handshake, ack is a single cycle per strobe
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wb_rsp <= '0;
            hold   <= 1'b0;
        end else begin
            wb_rsp.ack <= acc;
            hold       <= (wb_rsp.ack || hold) && wb_req.stb;
            if (acc) begin
                wb_rsp.dat <= wb_req.we ? 8'h00 : rd_dat;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register writes and the start trigger
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            base       <= '0;
            index      <= '0;
            offset     <= '0;
            length     <= '0;
            start_pend <= 1'b0;
            fetch      <= '0;
        end else begin
            start_pend  <= wr_acc && wb_req.adr == `DCU_PORT_OFFSET1;
            fetch.start <= start_pend;
            // Entry is four bytes, skip the mode byte
            if (start_pend) begin
                fetch.addr <= base + {index, 2'b00} + 1'b1;
            end

            if (wr_acc) begin
                case (wb_req.adr)
                    `DCU_PORT_BASE0:    base[7:0]    <= wb_req.dat;
                    `DCU_PORT_BASE1:    base[15:8]   <= wb_req.dat;
                    `DCU_PORT_BASE2:    base[23:16]  <= wb_req.dat;
                    `DCU_PORT_INDEX:    index        <= wb_req.dat;
                    `DCU_PORT_OFFSET0:  offset[7:0]  <= wb_req.dat;
                    `DCU_PORT_OFFSET1:  offset[15:8] <= wb_req.dat;
                    `DCU_PORT_COUNTER0: length[7:0]  <= wb_req.dat;
                    `DCU_PORT_COUNTER1: length[15:8] <= wb_req.dat;
                    default: ;
                endcase
            end

            // Length counts down with each byte handed out
            if (ring_pop) begin
                length <= length - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dcu_arbiter_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcu_consts.svh"

module dcu_arbiter_top (
    input  wire                     CLK,
    input  wire                     arst_n,
    input  wire dcu_pkg::wb_req_t   wb_req,
    output wire dcu_pkg::wb_rsp_t   wb_rsp,
    input  wire                     sfc_rom_rd,
    output wire                     rom_rd,
    output wire [`DCU_ROM_AW-1:0]   rom_addr,
    input  wire [15:0]              rom_data
);

    wire dcu_pkg::fetch_cmd_t fetch;
    wire dcu_pkg::rom_req_t   loader_req;
    wire dcu_pkg::rom_req_t   prefetch_req;
    wire dcu_pkg::rom_rsp_t   rom_rsp;
    wire dcu_pkg::ring_wr_t   ring_wr;
    wire [`DCU_RING_CW-1:0]   ring_count;
    wire [7:0]                ring_head;
    wire                      ring_pop;
    wire                      ptr_valid;
    wire [`DCU_PTR_W-1:0]     ptr;

    dcu_regs u_regs (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .ring_count (ring_count),
        .ring_head  (ring_head),
        .ring_pop   (ring_pop),
        .fetch      (fetch)
    );

    // Start pulse doubles as flush for the whole fetch path
    rom_port u_rom_port (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .flush        (fetch.start),
        .loader_req   (loader_req),
        .prefetch_req (prefetch_req),
        .rsp          (rom_rsp),
        .sfc_rom_rd   (sfc_rom_rd),
        .rom_rd       (rom_rd),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data)
    );

    dir_loader u_loader (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .fetch     (fetch),
        .req       (loader_req),
        .rsp       (rom_rsp),
        .ptr_valid (ptr_valid),
        .ptr       (ptr)
    );

    rom_prefetch u_prefetch (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .flush      (fetch.start),
        .ptr_valid  (ptr_valid),
        .ptr        (ptr),
        .ring_count (ring_count),
        .req        (prefetch_req),
        .rsp        (rom_rsp),
        .ring_wr    (ring_wr)
    );

    byte_ring #(
        .DEPTH (`DCU_RING_DEPTH)
    ) u_ring (
        .CLK    (CLK),
        .arst_n (arst_n),
        .flush  (fetch.start),
        .wr     (ring_wr),
        .pop    (ring_pop),
        .count  (ring_count),
        .head   (ring_head)
    );

endmodule

`default_nettype wire

//--- tb_dcu_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcu_consts.svh"

module tb_dcu_arbiter;

    // Directory layout in the ROM model
    localparam logic [23:0] DIR_BASE = 24'h000100;
    localparam logic [23:0] PTR0     = 24'h000400;
    localparam logic [23:0] PTR1     = 24'h000C01;
    localparam logic [23:0] PTR2     = 24'h001000;
    localparam logic [23:0] PTR3     = 24'h000803;

    // Bytes moved over the whole run including the ring fill
    localparam int TOTAL_BYTES = 64 + 64 + 128 + (`DCU_RING_DEPTH + 16) + 20 + 48
                                 + `DCU_RING_DEPTH;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 2 * (`DCU_ROM_LATENCY + 4) + 5000;
    localparam int ACK_LIMIT  = 8;
    localparam int POLL_LIMIT = 200;
    localparam int FILL_LIMIT = `DCU_RING_DEPTH * (`DCU_ROM_LATENCY + 4) + 200;

    logic                   CLK = 1'b0;
    logic                   arst_n;
    dcu_pkg::wb_req_t       wb_req;
    dcu_pkg::wb_rsp_t       wb_rsp;
    logic                   sfc_rom_rd;
    wire                    rom_rd;
    wire [`DCU_ROM_AW-1:0]  rom_addr;
    wire [15:0]             rom_data;

    logic [15:0] rom_mem [4096];
    integer      seed = 2;
    logic        sfc_noise = 1'b0;

    dcu_arbiter_top uut (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .sfc_rom_rd (sfc_rom_rd),
        .rom_rd     (rom_rd),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data)
    );

    always #2 CLK = ~CLK;

    // ROM model folds the upper address bits into the data so every bit counts
    assign rom_data = rom_mem[rom_addr[11:0]] ^ {5'b0, rom_addr[22:12]};

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and checks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            abort_run($sformatf("MISMATCH t=%0t %s expected=%h actual=%h",
                                $time, name, exp, act));
        end
    endtask

    // Even bytes sit in the low half of each word
    function automatic logic [7:0] expected_byte(input logic [23:0] b);
        logic [15:0] word;
        word = rom_mem[b[12:1]] ^ {5'b0, b[23:13]};
        return b[0] ? word[15:8] : word[7:0];
    endfunction

    task automatic set_rom_byte(input logic [23:0] b, input logic [7:0] v);
        if (b[0]) begin
            rom_mem[b[12:1]][15:8] = v;
        end else begin
            rom_mem[b[12:1]][7:0] = v;
        end
    endtask

    // Entry byte 0 is the mode and the pointer follows high byte first
    task automatic set_entry(input int idx, input logic [23:0] p);
        logic [23:0] e;
        e = DIR_BASE + 24'(4 * idx);
        set_rom_byte(e + 24'd1, p[23:16]);
        set_rom_byte(e + 24'd2, p[15:8]);
        set_rom_byte(e + 24'd3, p[7:0]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Wishbone driver
    //////////////////////////////////////////////////////////////////////

    task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [7:0] dat,
                           output logic [7:0] rdat);
        int waited;
        @(negedge CLK);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge CLK);
        waited = 1;
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        assert (wb_rsp.ack) else abort_run($sformatf("No ack for access to port %h", adr));
        check_eq("ack latency", 1, waited);
        rdat = wb_rsp.dat;
        // Strobe stays up one more cycle and ack must not repeat
        @(negedge CLK);
        assert (!wb_rsp.ack) else abort_run($sformatf("Second ack on port %h", adr));
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [7:0] dat);
        wb_xfer(1'b0, adr, 8'h00, dat);
    endtask

    task automatic read_counter(output logic [15:0] c);
        logic [7:0] lo;
        logic [7:0] hi;
        wb_read(`DCU_PORT_COUNTER0, lo);
        wb_read(`DCU_PORT_COUNTER1, hi);
        c = {hi, lo};
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream helpers
    //////////////////////////////////////////////////////////////////////

    task automatic start_lookup(input logic [7:0] idx, input logic [15:0] cnt);
        wb_write(`DCU_PORT_INDEX, idx);
        wb_write(`DCU_PORT_COUNTER0, cnt[7:0]);
        wb_write(`DCU_PORT_COUNTER1, cnt[15:8]);
        wb_write(`DCU_PORT_OFFSET0, 8'h00);
        // High offset byte kicks off the lookup
        wb_write(`DCU_PORT_OFFSET1, 8'h00);
    endtask

    task automatic wait_ready();
        logic [7:0] st;
        int polls;
        polls = 0;
        st = 8'h00;
        while (!st[`DCU_STATUS_READY_BIT] && polls < POLL_LIMIT) begin
            wb_read(`DCU_PORT_STATUS, st);
            polls++;
        end
        assert (st[`DCU_STATUS_READY_BIT]) else abort_run("STATUS ready bit never came up");
    endtask

    task automatic read_stream(input logic [23:0] p, input int n);
        logic [7:0] d;
        for (int i = 0; i < n; i++) begin
            wait_ready();
            wb_read(`DCU_PORT_DATA, d);
            check_eq($sformatf("DATA byte %0d from %h", i, p), expected_byte(p + 24'(i)), d);
        end
    endtask

    // Fill mode leaves the ring alone until the fetch side goes quiet
    task automatic run_stream(input logic [7:0] idx, input logic [23:0] p,
                              input logic [15:0] cnt, input int n, input logic fill);
        logic [15:0] c;
        int waited;
        start_lookup(idx, cnt);
        if (fill) begin
            waited = 0;
            while (uut.ring_count < `DCU_RING_DEPTH - 1 && waited < FILL_LIMIT) begin
                @(negedge CLK);
                waited++;
            end
            assert (uut.ring_count >= `DCU_RING_DEPTH - 1)
                else abort_run("Ring did not fill while reading was paused");
            repeat (50) begin
                @(negedge CLK);
                assert (!rom_rd) else abort_run("ROM read issued while the ring was full");
            end
        end
        read_stream(p, n);
        read_counter(c);
        check_eq("COUNTER", cnt - 16'(n), c);
    endtask

    task automatic check_registers();
        logic [7:0] d;
        logic [3:0] ports [8];
        ports = '{`DCU_PORT_BASE0, `DCU_PORT_BASE1, `DCU_PORT_BASE2, `DCU_PORT_INDEX,
                  `DCU_PORT_OFFSET0, `DCU_PORT_OFFSET1, `DCU_PORT_COUNTER0,
                  `DCU_PORT_COUNTER1};
        for (int i = 0; i < 8; i++) begin
            wb_write(ports[i], 8'(8'hA5 ^ (i * 8'h37)));
        end
        for (int i = 0; i < 8; i++) begin
            wb_read(ports[i], d);
            check_eq($sformatf("register port %h", ports[i]), 8'(8'hA5 ^ (i * 8'h37)), d);
        end
        // Holes in the map are 7, 8, B, D, E and F
        for (int a = 0; a < 16; a++) begin
            if (a == 7 || a == 8 || a == 11 || a >= 13) begin
                wb_write(4'(a), 8'hFF);
                wb_read(4'(a), d);
                check_eq($sformatf("undefined port %h", a), 0, d);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Cartridge traffic and ROM pin monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (arst_n) begin
            assert (!(rom_rd && sfc_rom_rd))
                else abort_run("rom_rd high in a cycle with a cartridge read");
        end
        // Roughly one cartridge read in eight cycles
        if (sfc_noise) begin
            sfc_rom_rd = ($random(seed) & 7) == 0;
        end else begin
            sfc_rom_rd = 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        abort_run($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]  d;
        logic [15:0] c;
        arst_n     = 1'b0;
        wb_req     = '0;
        sfc_rom_rd = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            rom_mem[i] = 16'($random(seed));
        end
        set_entry(0, PTR0);
        set_entry(1, PTR1);
        set_entry(2, PTR2);
        set_entry(3, PTR3);

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        check_eq("wb_rsp.ack after reset", 0, wb_rsp.ack);
        check_eq("rom_rd after reset", 0, rom_rd);

        check_registers();

        wb_write(`DCU_PORT_BASE0, DIR_BASE[7:0]);
        wb_write(`DCU_PORT_BASE1, DIR_BASE[15:8]);
        wb_write(`DCU_PORT_BASE2, DIR_BASE[23:16]);

        // Even and odd pointers
        run_stream(8'd0, PTR0, 16'h0100, 64, 1'b0);
        run_stream(8'd1, PTR1, 16'h0200, 64, 1'b0);

        // Cartridge pre-emption during the stream
        sfc_noise = 1'b1;
        run_stream(8'd0, PTR0, 16'h0200, 128, 1'b0);
        sfc_noise = 1'b0;

        // Full ring back-pressure
        run_stream(8'd2, PTR2, 16'h1000, `DCU_RING_DEPTH + 16, 1'b1);

        // Restart mid-stream and probe the empty ring during the lookup
        start_lookup(8'd1, 16'h0300);
        read_stream(PTR1, 20);
        start_lookup(8'd3, 16'h0300);
        read_counter(c);
        check_eq("COUNTER after restart", 16'h0300, c);
        wb_read(`DCU_PORT_STATUS, d);
        check_eq("STATUS ready during lookup", 0, d[`DCU_STATUS_READY_BIT]);
        wb_read(`DCU_PORT_DATA, d);
        check_eq("DATA on empty ring", 0, d);
        read_counter(c);
        check_eq("COUNTER after empty read", 16'h0300, c);
        read_stream(PTR3, 48);
        read_counter(c);
        check_eq("COUNTER after restart stream", 16'h0300 - 16'd48, c);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
dcu_pkg.sv
byte_ring.sv
rom_port.sv
dir_loader.sv
rom_prefetch.sv
dcu_regs.sv
dcu_arbiter_top.sv
tb_dcu_arbiter.sv

//--- Bender.yml
package:
  name: dcu_arbiter

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dcu_pkg.sv
      - byte_ring.sv
      - rom_port.sv
      - dir_loader.sv
      - rom_prefetch.sv
      - dcu_regs.sv
      - dcu_arbiter_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dcu_arbiter.sv
